// ==== spritePkg.sv ====
//****************************************************************************
// sprite layer package
// pixel, position, zone hit and collision structs
// object sizes, colour codes, APB register map and reset values
// shared pixel-in-span helper for the renderers
//****************************************************************************
package spritePkg;

	localparam int COORD_W = 11; // screen coordinate width
	localparam int COLOR_W = 8;  // 8-bit colour codes
	localparam int APB_AW = 8;   // APB address width
	localparam int APB_DW = 32;  // APB data width
	localparam int N_ZONES = 3;  // left, middle, right

	// current pixel on screen, always positive
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
	} pixel_t;

	// object top-left corner, may sit off screen
	typedef struct packed {
		logic signed [COORD_W-1:0] x;
		logic signed [COORD_W-1:0] y;
	} objPos_t;

	typedef struct packed {
		logic left;
		logic middle;
		logic right;
	} bracketHit_t; // which bracket zone holds the pixel

	typedef struct packed {
		logic left;
		logic middle;
		logic right;
	} collision_t; // bird overlapping each zone, same bit order as the register

	localparam int BRACKET_ZONE_W = 32;
	localparam int BRACKET_W = 96; // three zones
	localparam int BRACKET_H = 32;
	localparam int BIRD_SIZE = 16;

	localparam logic [COLOR_W-1:0] BRACKET_COLOR = 8'h5b;
	localparam logic [COLOR_W-1:0] TRANSPARENT_COLOR = 8'hFF; // nothing drawn

	// register map, byte offsets of 32-bit words
	localparam logic [APB_AW-1:0] ADDR_BRACKET_POS = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_BIRD_POS = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_BIRD_COLOR = 8'h08;
	localparam logic [APB_AW-1:0] ADDR_BG_COLOR = 8'h0C;
	localparam logic [APB_AW-1:0] ADDR_COLLISION = 8'h10;

	localparam int POS_X_LSB = 0;  // x in bits 10..0
	localparam int POS_Y_LSB = 16; // y in bits 26..16

	localparam objPos_t RESET_BRACKET_POS = '{x: 11'sd0, y: 11'sd0};
	localparam objPos_t RESET_BIRD_POS = '{x: 11'sd200, y: 11'sd100};
	localparam logic [COLOR_W-1:0] RESET_BIRD_COLOR = 8'hE0;
	localparam logic [COLOR_W-1:0] RESET_BG_COLOR = 8'h00;

	// true when pix lies in [origin+first, origin+first+len), signed compare
	function automatic logic inSpan(logic [COORD_W-1:0] pix, logic signed [COORD_W-1:0] origin,
			int first, int len);
		int p;
		int lo;
		p = int'(pix);            // zero extended
		lo = int'(origin) + first; // sign extended, may be negative
		return (p >= lo) && (p < lo + len);
	endfunction

endpackage

// ==== apbRegs.sv ====
//****************************************************************************
// APB slave for the sprite layer
// bracket and bird positions, bird and background colours
// sticky collision flags, write-one-to-clear
//****************************************************************************
`timescale 1ns/1ps

module apbRegs
	import spritePkg::*;
(
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_AW-1:0] paddr,
	input logic [APB_DW-1:0] pwdata,
	input collision_t collision, // per-pixel overlap from the mux
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output objPos_t bracketPos,
	output objPos_t birdPos,
	output logic [COLOR_W-1:0] birdColor,
	output logic [COLOR_W-1:0] bgColor
);

	logic access;   // second phase of a transfer
	logic mapped;   // offset hits a register
	logic wrEn;     // legal write in this access cycle
	logic [APB_DW-1:0] readData;
	collision_t stickyFlags;
	collision_t clearMask;

	assign access = psel && penable;
	assign pready = access; // no wait states
	assign pslverr = access && !mapped;
	assign wrEn = access && pwrite && mapped;

	// address decode and read mux
	always_comb begin
		mapped = 1'b1;
		readData = '0; // unused bits stay 0
		case (paddr)
			ADDR_BRACKET_POS: begin
				readData[POS_X_LSB +: COORD_W] = bracketPos.x;
				readData[POS_Y_LSB +: COORD_W] = bracketPos.y;
			end
			ADDR_BIRD_POS: begin
				readData[POS_X_LSB +: COORD_W] = birdPos.x;
				readData[POS_Y_LSB +: COORD_W] = birdPos.y;
			end
			ADDR_BIRD_COLOR: readData[COLOR_W-1:0] = birdColor;
			ADDR_BG_COLOR: readData[COLOR_W-1:0] = bgColor;
			ADDR_COLLISION: readData[N_ZONES-1:0] = stickyFlags;
			default: mapped = 1'b0; // hole in the map, reads 0
		endcase
	end

	// only drive data while a read is in its access phase
	assign prdata = (access && !pwrite) ? readData : '0;

	// write-one-to-clear mask for the collision register
	always_comb begin
		clearMask = '0;
		if (wrEn && (paddr == ADDR_COLLISION))
			clearMask = collision_t'(pwdata[N_ZONES-1:0]);
	end

	// configuration registers, written at the end of the access cycle
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			bracketPos <= RESET_BRACKET_POS;
			birdPos <= RESET_BIRD_POS;
			birdColor <= RESET_BIRD_COLOR;
			bgColor <= RESET_BG_COLOR;
		end
		else if (wrEn) begin
			case (paddr)
				ADDR_BRACKET_POS: begin
					bracketPos.x <= pwdata[POS_X_LSB +: COORD_W];
					bracketPos.y <= pwdata[POS_Y_LSB +: COORD_W];
				end
				ADDR_BIRD_POS: begin
					birdPos.x <= pwdata[POS_X_LSB +: COORD_W];
					birdPos.y <= pwdata[POS_Y_LSB +: COORD_W];
				end
				ADDR_BIRD_COLOR: birdColor <= pwdata[COLOR_W-1:0];
				ADDR_BG_COLOR: bgColor <= pwdata[COLOR_W-1:0];
				default: ; // collision handled below
			endcase
		end
	end

	// sticky flags: a new collision wins over a clear in the same cycle
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			stickyFlags <= '0;
		else
			stickyFlags <= (stickyFlags & ~clearMask) | collision;
	end

endmodule

// ==== bracketObject.sv ====
//****************************************************************************
// bracket renderer
// three 32-pixel zones side by side, one registered hit bit per zone
//****************************************************************************
`timescale 1ns/1ps

module bracketObject
	import spritePkg::*;
(
	input logic clk,
	input logic resetN,
	input pixel_t pixel,          // current screen pixel
	input objPos_t bracketPos,    // top-left corner, signed
	output bracketHit_t bracketHit // zone holding the pixel, one cycle later
);

	logic inRows;   // pixel row within the bracket height
	logic inCols;   // pixel column within the whole bracket
	bracketHit_t zoneHit;

	// signed compares so a partly off-screen bracket still draws
	always_comb begin
		inRows = inSpan(pixel.y, bracketPos.y, 0, BRACKET_H);
		inCols = inSpan(pixel.x, bracketPos.x, 0, BRACKET_W);
		zoneHit = '0;

		if (inRows && inCols) begin
			// zones are disjoint, priority only keeps it one-hot
			if (inSpan(pixel.x, bracketPos.x, 0, BRACKET_ZONE_W))
				zoneHit.left = 1'b1;   // offsets 0..31
			else if (inSpan(pixel.x, bracketPos.x, BRACKET_ZONE_W, BRACKET_ZONE_W))
				zoneHit.middle = 1'b1; // offsets 32..63
			else
				zoneHit.right = 1'b1;  // offsets 64..95
		end
	end

	// first pipeline stage
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			bracketHit <= '0;
		else
			bracketHit <= zoneHit;
	end

endmodule

// ==== birdObject.sv ====
//****************************************************************************
// bird renderer
// registered request for pixels inside the bird square
//****************************************************************************
`timescale 1ns/1ps

module birdObject
	import spritePkg::*;
(
	input logic clk,
	input logic resetN,
	input pixel_t pixel,     // current screen pixel
	input objPos_t birdPos,  // top-left corner, may be off screen
	output logic birdHit     // pixel inside the square, one cycle later
);

	logic inCols;
	logic inRows;

	// signed compare keeps the visible part of a clipped bird
	always_comb begin
		inCols = inSpan(pixel.x, birdPos.x, 0, BIRD_SIZE);
		inRows = inSpan(pixel.y, birdPos.y, 0, BIRD_SIZE);
	end

	// first pipeline stage, aligned with the bracket
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			birdHit <= 1'b0;
		else
			birdHit <= inCols && inRows;
	end

endmodule

// ==== objectsMux.sv ====
//****************************************************************************
// objects mux
// priority colour select: bird, then bracket, then background
// per-zone collision of the bird with the bracket
//****************************************************************************
`timescale 1ns/1ps

module objectsMux
	import spritePkg::*;
(
	input logic clk,
	input logic resetN,
	input bracketHit_t bracketHit,     // zone request from the bracket
	input logic birdHit,               // request from the bird
	input logic [COLOR_W-1:0] birdColor,
	input logic [COLOR_W-1:0] bgColor,
	output logic [COLOR_W-1:0] rgbOut, // pixel colour, two cycles after the pixel
	output collision_t collision       // overlap per zone, same stage as rgbOut
);

	logic birdVisible; // bird drawn only with an opaque colour
	logic bracketAny;
	logic [COLOR_W-1:0] pixelColor;
	collision_t overlap;

	// colour priority
	always_comb begin
		birdVisible = birdHit && (birdColor != TRANSPARENT_COLOR);
		bracketAny = |bracketHit;

		if (birdVisible)
			pixelColor = birdColor;
		else if (bracketAny)
			pixelColor = BRACKET_COLOR; // fixed bracket colour
		else
			pixelColor = bgColor;
	end

	// collisions use the raw request, a transparent bird still collides
	always_comb begin
		overlap.left = birdHit && bracketHit.left;
		overlap.middle = birdHit && bracketHit.middle;
		overlap.right = birdHit && bracketHit.right;
	end

	// second pipeline stage
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			rgbOut <= TRANSPARENT_COLOR; // nothing drawn until the pipe fills
			collision <= '0;
		end
		else begin
			rgbOut <= pixelColor;
			collision <= overlap;
		end
	end

endmodule

// ==== spriteLayer.sv ====
//****************************************************************************
// sprite layer top level
// APB register block, bracket and bird renderers, colour mux
//****************************************************************************
`timescale 1ns/1ps

module spriteLayer
	import spritePkg::*;
(
	input logic clk,
	input logic resetN,
	input pixel_t pixel, // new coordinate every clock
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_AW-1:0] paddr,
	input logic [APB_DW-1:0] pwdata,
	output logic [APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [COLOR_W-1:0] rgbOut // two cycles after pixel
);

	objPos_t bracketPos;
	objPos_t birdPos;
	logic [COLOR_W-1:0] birdColor;
	logic [COLOR_W-1:0] bgColor;
	bracketHit_t bracketHit; // stage 1
	logic birdHit;           // stage 1
	collision_t collision;   // stage 2, back to the sticky flags

	apbRegs regs_i (
		.clk(clk), .resetN(resetN),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .collision(collision),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.bracketPos(bracketPos), .birdPos(birdPos),
		.birdColor(birdColor), .bgColor(bgColor)
	);

	bracketObject bracket_i (
		.clk(clk), .resetN(resetN),
		.pixel(pixel), .bracketPos(bracketPos),
		.bracketHit(bracketHit)
	);

	birdObject bird_i (
		.clk(clk), .resetN(resetN),
		.pixel(pixel), .birdPos(birdPos),
		.birdHit(birdHit)
	);

	objectsMux mux_i (
		.clk(clk), .resetN(resetN),
		.bracketHit(bracketHit), .birdHit(birdHit),
		.birdColor(birdColor), .bgColor(bgColor),
		.rgbOut(rgbOut), .collision(collision)
	);

endmodule

// ==== spriteLayer_checker.sv ====
//****************************************************************************
// APB assertions for the sprite layer register block
// address decode, error, read data and reset rules, bound into apbRegs
//****************************************************************************
`timescale 1ns/1ps

module spriteLayer_checker
	import spritePkg::*;
(
	input logic clk,
	input logic resetN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [APB_AW-1:0] paddr,
	input logic pready,
	input logic pslverr,
	input logic [APB_DW-1:0] prdata,
	input objPos_t bracketPos,
	input objPos_t birdPos,
	input logic [COLOR_W-1:0] birdColor,
	input logic [COLOR_W-1:0] bgColor
);

	logic inMap; // offset is one of the five registers

	assign inMap = (paddr == ADDR_BRACKET_POS) || (paddr == ADDR_BIRD_POS) ||
		(paddr == ADDR_BIRD_COLOR) || (paddr == ADDR_BG_COLOR) ||
		(paddr == ADDR_COLLISION);

	// mapped access completes at once and without error
	mappedAccess: assert property (@(posedge clk) disable iff (!resetN)
		(psel && penable && inMap) |-> (pready && !pslverr))
		else $error("mapped access without pready or with pslverr");

	errWithReady: assert property (@(posedge clk) disable iff (!resetN)
		pslverr |-> (pready && !inMap)) // error only on a completing transfer to a hole
		else $error("pslverr high without pready or on a mapped offset");

	controlKnown: assert property (@(posedge clk) disable iff (!resetN)
		!$isunknown({pready, pslverr, prdata, bracketPos, birdPos, birdColor, bgColor}))
		else $error("register block output unknown after reset");

	// hole in the map reads 0
	holeReadsZero: assert property (@(posedge clk) disable iff (!resetN)
		(psel && penable && !pwrite && !inMap) |-> (prdata == '0))
		else $error("unmapped read returned data");

endmodule

bind apbRegs spriteLayer_checker chk_i (
	.clk(clk), .resetN(resetN),
	.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
	.pready(pready), .pslverr(pslverr), .prdata(prdata),
	.bracketPos(bracketPos), .birdPos(birdPos),
	.birdColor(birdColor), .bgColor(bgColor)
);

// ==== spriteLayer_tb.sv ====
//****************************************************************************
// directed testbench for the sprite layer
// APB transfer tasks, pixel drive, typed compare tasks
// reset, register, bracket zone, priority and collision tests
//****************************************************************************
`timescale 1ns/1ps

module spriteLayer_tb
	import spritePkg::*;
();

	logic clk;
	logic resetN;
	pixel_t pixel;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic [COLOR_W-1:0] rgbOut;

	int seed = 32'h900a6893;
	int errors = 0;
	int checks = 0;
	int waitLimit = 16; // cycles allowed for pready
	int park = 2040;    // pixel outside every object
	int bx;             // bracket corner used by the zone tests
	int by;

	spriteLayer dut_i (
		.clk(clk), .resetN(resetN), .pixel(pixel),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .rgbOut(rgbOut)
	);

	always #20 clk = ~clk; // 40 ns period

	task automatic abortRun(input string what);
		$display("Timeout: %s", what);
		$display("Checks failed");
		$finish;
	endtask

	task automatic checkWord(input logic [APB_DW-1:0] got, input logic [APB_DW-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkColor(input logic [COLOR_W-1:0] got, input logic [COLOR_W-1:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s colour %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCollision(input collision_t got, input collision_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s flags %b, expected %b", $time, what, got, exp);
		end
	endtask

	// setup cycle, access cycle, data sampled mid-cycle
	task automatic apbTransfer(input logic write, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] data, output logic [APB_DW-1:0] rdata, output logic err);
		int waited;
		waited = 0;
		@(posedge clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		checkWord({30'b0, pready, pslverr}, 32'd0, "pready and pslverr in setup cycle");
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);
		while (!pready && waited < waitLimit) begin
			waited++;
			@(negedge clk);
		end
		if (!pready)
			abortRun("APB slave never raised pready");
		else begin
			rdata = prdata;
			err = pslverr;
			@(posedge clk); // transfer ends here
			#2;
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	task automatic apbWrite(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
			output logic err);
		logic [APB_DW-1:0] unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] rdata,
			output logic err);
		apbTransfer(1'b0, addr, '0, rdata, err);
	endtask

	task automatic drivePixel(input int px, input int py);
		@(posedge clk);
		#2;
		pixel.x = px[COORD_W-1:0];
		pixel.y = py[COORD_W-1:0];
	endtask

	// colour of a pixel comes out two edges later
	task automatic checkPixel(input int px, input int py, input logic [COLOR_W-1:0] exp,
			input string what);
		drivePixel(px, py);
		@(posedge clk);
		@(posedge clk);
		#1;
		checkColor(rgbOut, exp, what);
	endtask

	function automatic logic [APB_DW-1:0] posWord(input int x, input int y);
		logic [APB_DW-1:0] w;
		w = '0;
		w[10:0] = x[10:0];
		w[26:16] = y[10:0];
		return w;
	endfunction

	function automatic int randRange(input int lo, input int span);
		return lo + int'($unsigned($random(seed)) % span);
	endfunction

	// zone rule: 32-pixel zones at x offsets 0, 32, 64, rows 0..31
	function automatic bracketHit_t zoneRule(input int px, input int py, input int ox,
			input int oy);
		bracketHit_t z;
		int dx;
		int dy;
		z = '0;
		dx = px - ox;
		dy = py - oy;
		if (dy >= 0 && dy < BRACKET_H && dx >= 0 && dx < BRACKET_W) begin
			case (dx / BRACKET_ZONE_W)
				0: z.left = 1'b1;
				1: z.middle = 1'b1;
				default: z.right = 1'b1;
			endcase
		end
		return z;
	endfunction

	task automatic expectBracketOrBg(input int px, input int py, input logic [COLOR_W-1:0] bg);
		logic [COLOR_W-1:0] exp;
		exp = (|zoneRule(px, py, bx, by)) ? BRACKET_COLOR : bg;
		checkPixel(px, py, exp, "bracket zone pixel");
	endtask

	task automatic resetValuesTest();
		logic [APB_DW-1:0] rd;
		logic err;
		apbRead(ADDR_BRACKET_POS, rd, err);
		checkWord(rd, posWord(0, 0), "reset bracket position");
		apbRead(ADDR_BIRD_POS, rd, err);
		checkWord(rd, posWord(200, 100), "reset bird position");
		apbRead(ADDR_BIRD_COLOR, rd, err);
		checkWord(rd, 32'h0000_00E0, "reset bird colour");
		apbRead(ADDR_BG_COLOR, rd, err);
		checkWord(rd, 32'h0000_0000, "reset background colour");
		apbRead(ADDR_COLLISION, rd, err);
		checkCollision(collision_t'(rd[2:0]), '0, "reset collision");
		checkWord(rd, '0, "reset collision word");
	endtask

	task automatic registerTest();
		logic [APB_DW-1:0] w;
		logic [APB_DW-1:0] rd;
		logic [APB_DW-1:0] mask;
		logic err;
		for (int i = 0; i < 4; i++) begin
			mask = (i < 2) ? 32'h07FF_07FF : 32'h0000_00FF; // positions, then colours
			w = $random(seed);
			apbWrite(8'(i * 4), w, err);
			checkWord({31'b0, err}, 32'd0, "pslverr on mapped write");
			apbRead(8'(i * 4), rd, err);
			checkWord(rd, w & mask, "register readback");
		end
		apbWrite(8'h14, 32'hFFFF_FFFF, err);
		checkWord({31'b0, err}, 32'd1, "pslverr on unmapped write");
		apbRead(8'h14, rd, err);
		checkWord({31'b0, err}, 32'd1, "pslverr on unmapped read");
		checkWord(rd, '0, "unmapped read data");
	endtask

	task automatic bracketZoneTest();
		logic [COLOR_W-1:0] bg;
		logic err;
		bx = randRange(64, 400);
		by = randRange(64, 300);
		bg = 8'($random(seed));
		if (bg == BRACKET_COLOR)
			bg = ~bg;
		apbWrite(ADDR_BIRD_POS, posWord(-100, -100), err); // bird off screen
		apbWrite(ADDR_BG_COLOR, {24'b0, bg}, err);
		apbWrite(ADDR_BRACKET_POS, posWord(bx, by), err);
		for (int z = 0; z < 3; z++)
			expectBracketOrBg(bx + z * BRACKET_ZONE_W + randRange(0, BRACKET_ZONE_W),
				by + randRange(0, BRACKET_H), bg);
		expectBracketOrBg(bx, by, bg); // corners and zone edges
		expectBracketOrBg(bx + 31, by + 31, bg);
		expectBracketOrBg(bx + 32, by, bg);
		expectBracketOrBg(bx + 95, by + 31, bg);
		expectBracketOrBg(bx - 1, by, bg); // just outside
		expectBracketOrBg(bx + BRACKET_W, by + 5, bg);
		expectBracketOrBg(bx + 10, by - 1, bg);
		expectBracketOrBg(bx + 40, by + BRACKET_H, bg);
	endtask

	task automatic priorityTest();
		logic [COLOR_W-1:0] birdCol;
		logic err;
		birdCol = 8'($random(seed));
		if (birdCol == TRANSPARENT_COLOR || birdCol == BRACKET_COLOR)
			birdCol = 8'h1C;
		// bird square sits inside the middle zone
		apbWrite(ADDR_BIRD_POS, posWord(bx + 40, by + 8), err);
		apbWrite(ADDR_BIRD_COLOR, {24'b0, birdCol}, err);
		checkPixel(bx + 40, by + 8, birdCol, "bird over bracket");
		checkPixel(bx + 55, by + 23, birdCol, "bird corner over bracket");
		checkPixel(bx + 56, by + 23, BRACKET_COLOR, "bracket beside bird");
		apbWrite(ADDR_BIRD_COLOR, {24'b0, TRANSPARENT_COLOR}, err);
		checkPixel(bx + 40, by + 8, BRACKET_COLOR, "transparent bird");
	endtask

	task automatic collisionTest();
		logic [APB_DW-1:0] rd;
		logic err;
		collision_t exp;
		exp = '0;
		apbWrite(ADDR_BIRD_POS, posWord(bx + 70, by + 20), err); // lower part of right zone
		drivePixel(park, park);
		repeat (4) @(posedge clk); // drain the pipeline
		apbWrite(ADDR_COLLISION, 32'h7, err);
		apbRead(ADDR_COLLISION, rd, err);
		checkCollision(collision_t'(rd[2:0]), '0, "flags before sweep");
		for (int y = by + 20; y < by + BRACKET_H; y++) begin
			for (int x = bx + 70; x < bx + 70 + BIRD_SIZE; x++) begin
				drivePixel(x, y);
				exp = exp | collision_t'(zoneRule(x, y, bx, by));
			end
		end
		drivePixel(park, park);
		repeat (4) @(posedge clk);
		apbRead(ADDR_COLLISION, rd, err);
		checkCollision(collision_t'(rd[2:0]), exp, "flags after sweep");
		apbWrite(ADDR_COLLISION, {29'b0, exp}, err); // write one to clear
		apbRead(ADDR_COLLISION, rd, err);
		checkCollision(collision_t'(rd[2:0]), '0, "flags after clear");
		repeat (8) @(posedge clk);
		apbRead(ADDR_COLLISION, rd, err);
		checkCollision(collision_t'(rd[2:0]), '0, "flags stay clear");
	endtask

	initial begin
		clk = 1'b0;
		resetN = 1'b0;
		pixel.x = park[COORD_W-1:0];
		pixel.y = park[COORD_W-1:0];
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (5) @(posedge clk);
		#2;
		resetN = 1'b1;
		resetValuesTest();
		registerTest();
		bracketZoneTest();
		priorityTest();
		collisionTest();
		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== files.f ====
spritePkg.sv
apbRegs.sv
bracketObject.sv
birdObject.sv
objectsMux.sv
spriteLayer.sv
spriteLayer_checker.sv
spriteLayer_tb.sv
